// File: Makefile
# Verilator build and run for the RV32I core testbench.

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS    ?=

COMMON_FLAGS = --timing --assert --timescale $(TIMESCALE) \
               -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) $(VFLAGS)

# The binary exits nonzero when the testbench calls $fatal.
sim:
	$(VERILATOR) --binary $(COMMON_FLAGS) -Mdir $(OBJ_DIR) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: core_asserts.sv
`timescale 1ns/10ps

module core_asserts (
    input logic                                clk,
    input logic                                arst_n,
    input logic [rv_isa_pkg::INST_W-1:0]       inst,
    input logic [core_cmd_pkg::XLEN-1:0]       pc,
    input logic                                wb_en,
    input logic [core_cmd_pkg::REG_ADDR_W-1:0] wb_addr,
    input logic                                halted,
    input core_cmd_pkg::exu_cmd_e              cmd
);

    logic        lui_writes;
    int unsigned num_failures = 0;

    // A live lui with a nonzero rd must write back.
    assign lui_writes = !halted
                        && (rv_isa_pkg::rv_opcode_e'(inst[6:0]) == rv_isa_pkg::LUI)
                        && (inst[11:7] != 5'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Halt behavior
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    halted_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else begin
            num_failures++;
            $error("halted dropped without a reset");
        end

    pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> $stable(pc))
        else begin
            num_failures++;
            $error("pc moved while halted");
        end

    halt_cmd_sets_halted: assert property (@(posedge clk) disable iff (!arst_n)
        (cmd == core_cmd_pkg::CMD_HALT) |=> halted)
        else begin
            num_failures++;
            $error("halt command did not set halted");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    no_write_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_en && halted))
        else begin
            num_failures++;
            $error("write-back enabled while halted");
        end

    no_write_to_x0: assert property (@(posedge clk) disable iff (!arst_n)
        wb_en |-> (wb_addr != 5'd0))
        else begin
            num_failures++;
            $error("write-back enabled with destination x0");
        end

    lui_has_write: assert property (@(posedge clk) disable iff (!arst_n)
        lui_writes |-> wb_en)
        else begin
            num_failures++;
            $error("lui with nonzero rd did not write back");
        end

endmodule

bind core_top core_asserts asserts0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .inst    (inst),
    .pc      (pc),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .halted  (halted),
    .cmd     (cmd)
);

// File: core_cmd_pkg.sv
package core_cmd_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // First fetch address after reset.
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // Commands from decode to execute.
    typedef enum logic [3:0] {
        CMD_NOP  = 4'd0,
        CMD_ADD  = 4'd1,
        CMD_EQU  = 4'd2,   // result is src1
        CMD_HALT = 4'd3
    } exu_cmd_e;

endpackage

// File: core_exu.sv
`timescale 1ns/10ps

module core_exu (
    input  logic [core_cmd_pkg::XLEN-1:0]       src1,
    input  logic [core_cmd_pkg::XLEN-1:0]       src2,
    input  logic [core_cmd_pkg::REG_ADDR_W-1:0] rd,
    input  core_cmd_pkg::exu_cmd_e              cmd,
    output logic                                wb_en,
    output logic [core_cmd_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_cmd_pkg::XLEN-1:0]       wb_data,
    output logic                                halt_req
);

    logic writes_rd;

    always_comb begin
        writes_rd = 1'b0;
        wb_data   = '0;
        halt_req  = 1'b0;

        case (cmd)
            core_cmd_pkg::CMD_ADD: begin
                writes_rd = 1'b1;
                wb_data   = src1 + src2;
            end
            core_cmd_pkg::CMD_EQU: begin
                writes_rd = 1'b1;
                wb_data   = src1;
            end
            core_cmd_pkg::CMD_HALT: begin
                halt_req = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // No write-back to x0.
    assign wb_en   = writes_rd && (rd != '0);
    assign wb_addr = rd;

endmodule

// File: core_idu.sv
`timescale 1ns/10ps

module core_idu (
    input  logic [rv_isa_pkg::INST_W-1:0]       inst,
    input  logic [core_cmd_pkg::XLEN-1:0]       pc,
    input  logic [core_cmd_pkg::XLEN-1:0]       rdata1,
    input  logic [core_cmd_pkg::XLEN-1:0]       rdata2,
    input  logic                                halted,
    output logic [core_cmd_pkg::REG_ADDR_W-1:0] raddr1,
    output logic [core_cmd_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [core_cmd_pkg::REG_ADDR_W-1:0] rd,
    output logic [core_cmd_pkg::XLEN-1:0]       src1,
    output logic [core_cmd_pkg::XLEN-1:0]       src2,
    output core_cmd_pkg::exu_cmd_e              cmd
);

    rv_isa_pkg::rv_opcode_e        opcode;
    rv_isa_pkg::imm_fmt_e          imm_fmt;
    core_cmd_pkg::exu_cmd_e        dec_cmd;
    logic [2:0]                    funct3;
    logic [core_cmd_pkg::XLEN-1:0] imm;
    logic                          reg1_ren;
    logic                          rd_wen;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode = rv_isa_pkg::rv_opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    // Unused register fields are forced to x0.
    assign raddr1 = reg1_ren ? inst[19:15] : '0;
    assign rd     = rd_wen   ? inst[11:7]  : '0;

    // No supported instruction reads rs2.
    assign raddr2 = '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (imm_fmt)
            rv_isa_pkg::IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_isa_pkg::IMM_U: imm = {inst[31:12], 12'b0};
            default:           imm = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand and command select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // Defaults give a no-op that writes nothing.
        imm_fmt  = rv_isa_pkg::IMM_N;
        dec_cmd  = core_cmd_pkg::CMD_NOP;
        src1     = '0;
        src2     = rdata2;   // raddr2 stays x0 here, so this is zero.
        reg1_ren = 1'b0;
        rd_wen   = 1'b0;

        case (opcode)
            rv_isa_pkg::OP_IMM: begin
                if (funct3 == rv_isa_pkg::FUNCT3_ADDI) begin
                    imm_fmt  = rv_isa_pkg::IMM_I;
                    dec_cmd  = core_cmd_pkg::CMD_ADD;
                    src1     = imm;
                    src2     = rdata1;
                    reg1_ren = 1'b1;
                    rd_wen   = 1'b1;
                end
            end
            rv_isa_pkg::LUI: begin
                imm_fmt = rv_isa_pkg::IMM_U;
                dec_cmd = core_cmd_pkg::CMD_EQU;
                src1    = imm;
                src2    = '0;
                rd_wen  = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                imm_fmt = rv_isa_pkg::IMM_U;
                dec_cmd = core_cmd_pkg::CMD_ADD;
                src1    = pc;
                src2    = imm;
                rd_wen  = 1'b1;
            end
            rv_isa_pkg::SYSTEM: begin
                // ebreak.
                dec_cmd = core_cmd_pkg::CMD_HALT;
            end
            default: begin
            end
        endcase
    end

    // A halted core issues nothing more.
    assign cmd = halted ? core_cmd_pkg::CMD_NOP : dec_cmd;

endmodule

// File: core_ifu.sv
`timescale 1ns/10ps

module core_ifu (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          halt_req,
    output logic                          halted,
    output logic [core_cmd_pkg::XLEN-1:0] pc
);

    logic                          stop;
    logic [core_cmd_pkg::XLEN-1:0] pc_next;

    // Once halted the core stays halted until reset.
    assign stop    = halted | halt_req;
    assign pc_next = pc + core_cmd_pkg::XLEN'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (halt_req) begin
            halted <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= core_cmd_pkg::RESET_PC;
        end else if (!stop) begin
            pc <= pc_next;
        end
    end

endmodule

// File: core_regfile.sv
`timescale 1ns/10ps

module core_regfile (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [core_cmd_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [core_cmd_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [core_cmd_pkg::XLEN-1:0]       rdata1,
    output logic [core_cmd_pkg::XLEN-1:0]       rdata2,
    input  logic                                we,
    input  logic [core_cmd_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [core_cmd_pkg::XLEN-1:0]       wdata
);

    localparam int NUM_REGS = 1 << core_cmd_pkg::REG_ADDR_W;

    logic [core_cmd_pkg::XLEN-1:0] regs [NUM_REGS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // x0 is hardwired to zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: core_tb.sv
`timescale 1ns/10ps

module core_tb;

    localparam int CLK_PERIOD = 100;

    logic                                clk;
    logic                                arst_n;
    logic [rv_isa_pkg::INST_W-1:0]       inst;
    logic [core_cmd_pkg::XLEN-1:0]       pc;
    logic                                wb_en;
    logic [core_cmd_pkg::REG_ADDR_W-1:0] wb_addr;
    logic [core_cmd_pkg::XLEN-1:0]       wb_data;
    logic                                halted;

    // One entry per trace line.
    logic [rv_isa_pkg::INST_W-1:0]       tr_inst [$];
    logic [core_cmd_pkg::XLEN-1:0]       tr_pc [$];
    logic                                tr_wb_en [$];
    logic [core_cmd_pkg::REG_ADDR_W-1:0] tr_wb_addr [$];
    logic [core_cmd_pkg::XLEN-1:0]       tr_wb_data [$];
    logic                                tr_halted [$];

    int num_lines;
    bit trace_ready;

    core_top dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halted  (halted)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pc(input string where,
                            input logic [core_cmd_pkg::XLEN-1:0] got,
                            input logic [core_cmd_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s pc got %h expected %h",
                               $time, where, got, exp));
        end
    endtask

    task automatic check_wb(input string where,
                            input logic got_en,
                            input logic [core_cmd_pkg::REG_ADDR_W-1:0] got_addr,
                            input logic [core_cmd_pkg::XLEN-1:0] got_data,
                            input logic exp_en,
                            input logic [core_cmd_pkg::REG_ADDR_W-1:0] exp_addr,
                            input logic [core_cmd_pkg::XLEN-1:0] exp_data);
        if (got_en !== exp_en) begin
            fail_run($sformatf("ERROR at %0t ns: %s wb_en got %b expected %b",
                               $time, where, got_en, exp_en));
        end
        // Address and data only matter when a write happens.
        if (exp_en && (got_addr !== exp_addr)) begin
            fail_run($sformatf("ERROR at %0t ns: %s wb_addr got x%0d expected x%0d",
                               $time, where, got_addr, exp_addr));
        end
        if (exp_en && (got_data !== exp_data)) begin
            fail_run($sformatf("ERROR at %0t ns: %s wb_data got %h expected %h",
                               $time, where, got_data, exp_data));
        end
    endtask

    task automatic check_halt(input string where, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s halted got %b expected %b",
                               $time, where, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Trace file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_trace();
        int                                  fd;
        int                                  n;
        logic [8*128-1:0]                    text;
        logic [rv_isa_pkg::INST_W-1:0]       f_inst;
        logic [core_cmd_pkg::XLEN-1:0]       f_pc;
        logic                                f_en;
        logic [core_cmd_pkg::REG_ADDR_W-1:0] f_addr;
        logic [core_cmd_pkg::XLEN-1:0]       f_data;
        logic                                f_halt;

        fd = $fopen("core_trace.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the trace file core_trace.txt");
        end
        while ($feof(fd) == 0) begin
            text = '0;
            if ($fgets(text, fd) != 0) begin
                // Comment and blank lines do not scan as six fields.
                n = $sscanf(text, "%h %h %h %h %h %h",
                            f_inst, f_pc, f_en, f_addr, f_data, f_halt);
                if (n == 6) begin
                    tr_inst.push_back(f_inst);
                    tr_pc.push_back(f_pc);
                    tr_wb_en.push_back(f_en);
                    tr_wb_addr.push_back(f_addr);
                    tr_wb_data.push_back(f_data);
                    tr_halted.push_back(f_halt);
                end
            end
        end
        $fclose(fd);
        num_lines = tr_inst.size();
        if (num_lines == 0) begin
            fail_run("The trace file core_trace.txt holds no data lines");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, watchdog and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (trace_ready);
        #((num_lines + 10) * CLK_PERIOD);
        fail_run("Watchdog expired before the trace was finished");
    end

    initial begin
        arst_n = 1'b0;
        inst   = '0;
        load_trace();
        trace_ready = 1'b1;

        @(posedge clk);
        @(negedge clk);
        check_pc("reset", pc, core_cmd_pkg::RESET_PC);
        check_halt("reset", halted, 1'b0);

        // Release on the second edge and present the first instruction.
        @(posedge clk);
        arst_n <= 1'b1;
        inst   <= tr_inst[0];

        for (int i = 0; i < num_lines; i++) begin
            @(negedge clk);
            check_pc($sformatf("trace line %0d", i), pc, tr_pc[i]);
            check_wb($sformatf("trace line %0d", i), wb_en, wb_addr, wb_data,
                     tr_wb_en[i], tr_wb_addr[i], tr_wb_data[i]);
            check_halt($sformatf("trace line %0d", i), halted, tr_halted[i]);
            if (i + 1 < num_lines) begin
                @(posedge clk);
                inst <= tr_inst[i + 1];
            end
        end

        if (dut0.asserts0.num_failures != 0) begin
            fail_run("A bound assertion on the core failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [rv_isa_pkg::INST_W-1:0]       inst,
    output logic [core_cmd_pkg::XLEN-1:0]       pc,
    output logic                                wb_en,
    output logic [core_cmd_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_cmd_pkg::XLEN-1:0]       wb_data,
    output logic                                halted
);

    logic [core_cmd_pkg::REG_ADDR_W-1:0] raddr1;
    logic [core_cmd_pkg::REG_ADDR_W-1:0] raddr2;
    logic [core_cmd_pkg::REG_ADDR_W-1:0] rd;
    logic [core_cmd_pkg::XLEN-1:0]       rdata1;
    logic [core_cmd_pkg::XLEN-1:0]       rdata2;
    logic [core_cmd_pkg::XLEN-1:0]       src1;
    logic [core_cmd_pkg::XLEN-1:0]       src2;
    core_cmd_pkg::exu_cmd_e              cmd;
    logic                                halt_req;

    core_ifu ifu0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .halt_req (halt_req),
        .halted   (halted),
        .pc       (pc)
    );

    core_idu idu0 (
        .inst   (inst),
        .pc     (pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .halted (halted),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rd     (rd),
        .src1   (src1),
        .src2   (src2),
        .cmd    (cmd)
    );

    core_regfile regfile0 (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    core_exu exu0 (
        .src1     (src1),
        .src2     (src2),
        .rd       (rd),
        .cmd      (cmd),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .halt_req (halt_req)
    );

endmodule

// File: core_trace.txt
# Columns in hex: inst pc wb_en wb_addr wb_data halted
# wb_addr and wb_data are only compared when wb_en is 1
00500093 80000000 1 01 00000005 0
ffd08113 80000004 1 02 00000002 0
7ff10193 80000008 1 03 00000801 0
80000213 8000000c 1 04 fffff800 0
fff20293 80000010 1 05 fffff7ff 0
12345337 80000014 1 06 12345000 0
67830313 80000018 1 06 12345678 0
98830693 8000001c 1 0d 12345000 0
fffff3b7 80000020 1 07 fffff000 0
fff38793 80000024 1 0f ffffefff 0
00001417 80000028 1 08 80001028 0
00000497 8000002c 1 09 8000002c 0
80000717 80000030 1 0e 00000030 0
06408013 80000034 0 00 00000000 0
00700513 80000038 1 0a 00000007 0
00000013 8000003c 0 00 00000000 0
1234560b 80000040 0 00 00000000 0
00000000 80000044 0 00 00000000 0
0010c593 80000048 0 00 00000000 0
00209613 8000004c 0 00 00000000 0
0090a813 80000050 0 00 00000000 0
00106893 80000054 0 00 00000000 0
00150593 80000058 1 0b 00000008 0
00058613 8000005c 1 0c 00000008 0
ff860f93 80000060 1 1f 00000000 0
000f8f13 80000064 1 1e 00000000 0
00100073 80000068 0 00 00000000 0
00100693 80000068 0 00 00000000 1
abcde737 80000068 0 00 00000000 1
00100073 80000068 0 00 00000000 1
00108093 80000068 0 00 00000000 1
00000013 80000068 0 00 00000000 1

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int INST_W = 32;

    // funct3 of addi within OP-IMM.
    localparam logic [2:0] FUNCT3_ADDI = 3'b000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes, inst[6:0]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [6:0] {
        OP_IMM = 7'b00100_11,
        LUI    = 7'b01101_11,
        AUIPC  = 7'b00101_11,
        SYSTEM = 7'b11100_11
    } rv_opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediate formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Only the formats this decoder builds.
    typedef enum logic [1:0] {
        IMM_N = 2'd0,
        IMM_I = 2'd1,
        IMM_U = 2'd2
    } imm_fmt_e;

endpackage

// File: src.f
rv_isa_pkg.sv
core_cmd_pkg.sv
core_ifu.sv
core_idu.sv
core_regfile.sv
core_exu.sv
core_top.sv
core_asserts.sv
core_tb.sv
